/* source/enc_config.svh */
// Shared constants for the quadrature encoder interface.
// Included by the package and by any module or testbench that needs
// the counter width, the dropped low bits or the APB register map.
`ifndef ENC_CONFIG_SVH
`define ENC_CONFIG_SVH

// ----------------------------------------------------------------------
// interval counter
// ----------------------------------------------------------------------
`define ENC_CNT_WIDTH 26        // default width of the interval counter
`define ENC_DROP_BITS 4         // low bits dropped from reported counts

// ----------------------------------------------------------------------
// APB register map, byte addresses
// ----------------------------------------------------------------------
`define ENC_ADDR_POSITION 8'h00 // signed position count
`define ENC_ADDR_PERIOD   8'h04 // full-cycle period, overflow, direction
`define ENC_ADDR_ACCEL    8'h08 // newest and oldest quarter intervals
`define ENC_ADDR_TCUR     8'h0c // time since last edge
`define ENC_ADDR_STATUS   8'h10 // sticky illegal flag, direction
`define ENC_ADDR_CTRL     8'h14 // position clear, error clear

`endif

/* source/enc_pkg.sv */
// Types shared between the encoder blocks.
// Edge kinds, the register address map and the structs that carry
// events from decode to the period block and measurements to the
// register block.
`default_nettype none

`include "enc_config.svh"

package enc_pkg;

    // which line moved and which way
    typedef enum logic [1:0] {
        a_up = 2'b00,
        b_up = 2'b01,
        a_dn = 2'b10,
        b_dn = 2'b11
    } edge_kind_t;

    // APB register addresses, paddr decodes straight into this
    typedef enum logic [7:0] {
        reg_position = `ENC_ADDR_POSITION,
        reg_period   = `ENC_ADDR_PERIOD,
        reg_accel    = `ENC_ADDR_ACCEL,
        reg_tcur     = `ENC_ADDR_TCUR,
        reg_status   = `ENC_ADDR_STATUS,
        reg_ctrl     = `ENC_ADDR_CTRL
    } enc_reg_t;

    typedef struct packed {
        logic       valid;   // one-cycle edge strobe
        edge_kind_t kind;
        logic       dir;     // 1 = forward, a leads b
        logic       illegal; // both lines moved at once
    } enc_event_t;

    typedef struct packed {
        logic [31:0] period; // [31] ovf, [30] dir, [21:0] sum of 4 quarters
        logic [31:0] accel;  // [31:16] newest, [15:0] fifth quarter
        logic [31:0] t_cur;  // cycles since last edge
    } enc_meas_t;

endpackage

`default_nettype wire

/* source/enc_edge_decode.sv */
// Quadrature edge decoder.
// Brings the raw a and b lines into the clk domain, turns each level
// change into one event strobe with kind, direction and illegal flag,
// and keeps the signed position count. Event is 3 cycles after a pin
// change; position moves on the same edge as the event.
`timescale 1ns/1ps
`default_nettype none

module enc_edge_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                a,
    input  logic                b,
    input  logic                clear_position, // one-cycle pulse from regs
    output enc_pkg::enc_event_t evt,
    output logic signed [31:0]  position
);
    import enc_pkg::*;

    logic [1:0] a_sync;   // [0] first flop, [1] second flop
    logic [1:0] b_sync;
    logic       a_prev;   // last synchronized pair
    logic       b_prev;
    logic       a_chg;
    logic       b_chg;
    enc_event_t evt_next;

    assign a_chg = a_sync[1] ^ a_prev;
    assign b_chg = b_sync[1] ^ b_prev;

    // forward order of (a,b) is 00 -> 10 -> 11 -> 01 -> 00
    always_comb begin
        evt_next         = '0;
        evt_next.valid   = a_chg | b_chg;
        evt_next.illegal = a_chg & b_chg;   // skipped a state
        if (a_chg) begin
            evt_next.kind = a_sync[1] ? a_up : a_dn;
            evt_next.dir  = a_sync[1] ^ b_sync[1];    // a moved away from b
        end else begin
            evt_next.kind = b_sync[1] ? b_up : b_dn;
            evt_next.dir  = ~(a_sync[1] ^ b_sync[1]); // b caught up with a
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            a_sync   <= '0;
            b_sync   <= '0;
            a_prev   <= 1'b0;
            b_prev   <= 1'b0;
            evt      <= '0;
            position <= '0;
        end else begin
            a_sync <= {a_sync[0], a};
            b_sync <= {b_sync[0], b};
            a_prev <= a_sync[1];
            b_prev <= b_sync[1];
            evt    <= evt_next;
            if (clear_position)                          // clear wins over a step
                position <= '0;
            else if (evt_next.valid && !evt_next.illegal)
                position <= evt_next.dir ? position + 32'sd1 : position - 32'sd1;
        end
    end

endmodule

`default_nettype wire

/* source/enc_period_meas.sv */
// Encoder period measurement.
// A free-running interval counter is latched into a five-deep queue on
// every legal edge, newest first. The full-cycle period is the sum of
// the four newest quarter intervals; the accel word pairs the newest
// with the fifth entry, which belongs to the same edge kind one cycle
// back. The queue and the derived words move one cycle after evt.valid.
`timescale 1ns/1ps
`default_nettype none

`include "enc_config.svh"

module enc_period_meas #(
    parameter int CNT_WIDTH = `ENC_CNT_WIDTH
) (
    input  logic                clk,
    input  logic                reset,
    input  enc_pkg::enc_event_t evt,
    output enc_pkg::enc_meas_t  meas
);

    localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;   // saturated count
    localparam int SUM_WIDTH = CNT_WIDTH + 2;        // room for four entries

    logic [CNT_WIDTH-1:0] run_cnt;       // cycles since last legal edge
    logic [CNT_WIDTH-1:0] run_inc;
    logic [CNT_WIDTH-1:0] queue [5];     // [0] newest .. [4] oldest
    logic                 dir_q;         // direction of last legal edge
    logic                 step;
    logic [SUM_WIDTH-1:0] sum;
    logic [SUM_WIDTH-1:0] sum_sat;
    logic [31:0]          sum_shift;
    logic [21:0]          period_field;
    logic                 ovf;

    // drop low bits and clamp a queue entry to one accel half
    function automatic logic [15:0] sat16(input logic [CNT_WIDTH-1:0] v);
        logic [31:0] s;
        s = 32'(v >> `ENC_DROP_BITS);
        return (s > 32'h0000_ffff) ? 16'hffff : s[15:0];
    endfunction

    assign step    = evt.valid & ~evt.illegal;   // illegal edges are not timed
    assign run_inc = (run_cnt == CNT_MAX) ? CNT_MAX : run_cnt + 1'b1;

    // ------------------------------------------------------------------
    // interval counter and queue
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            run_cnt <= CNT_MAX;                  // start out as "too slow"
            for (int i = 0; i < 5; i++)
                queue[i] <= CNT_MAX;
            dir_q <= 1'b0;
        end else if (step) begin
            run_cnt  <= '0;
            queue[0] <= run_inc;                 // +1 counts the edge cycle itself
            for (int i = 1; i < 5; i++)
                queue[i] <= queue[i-1];
            dir_q <= evt.dir;
        end else begin
            run_cnt <= run_inc;                  // holds at CNT_MAX
        end
    end

    // ------------------------------------------------------------------
    // period, accel and time-since-edge words
    // ------------------------------------------------------------------
    assign sum = SUM_WIDTH'(queue[0]) + SUM_WIDTH'(queue[1])
               + SUM_WIDTH'(queue[2]) + SUM_WIDTH'(queue[3]);

    // a saturated entry means the real interval is unknown
    assign ovf = (sum > SUM_WIDTH'(CNT_MAX))
               || (queue[0] == CNT_MAX) || (queue[1] == CNT_MAX)
               || (queue[2] == CNT_MAX) || (queue[3] == CNT_MAX);

    assign sum_sat   = (sum > SUM_WIDTH'(CNT_MAX)) ? SUM_WIDTH'(CNT_MAX) : sum;
    assign sum_shift = 32'(sum_sat >> `ENC_DROP_BITS);
    assign period_field = (sum_shift > 32'h003f_ffff) ? 22'h3f_ffff : sum_shift[21:0];

    assign meas.period = {ovf, dir_q, 8'd0, period_field};
    assign meas.accel  = {sat16(queue[0]), sat16(queue[4])};
    assign meas.t_cur  = 32'(run_cnt >> `ENC_DROP_BITS);

endmodule

`default_nettype wire

/* source/enc_apb_regs.sv */
// APB register port of the encoder interface.
// Zero wait states: read data and the error response are registered in
// the setup cycle and shown in the access cycle. A CTRL write clears the
// position (bit 0, one-cycle pulse to decode) and the sticky illegal
// flag (bit 1) at the end of the access cycle.
`timescale 1ns/1ps
`default_nettype none

module enc_apb_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [7:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  enc_pkg::enc_event_t evt,
    input  logic signed [31:0]  position,
    input  enc_pkg::enc_meas_t  meas,
    output logic                clear_position
);
    import enc_pkg::*;

    logic        setup;      // first cycle of a transfer
    logic        access;     // second cycle, penable high
    logic        addr_ok;
    logic        wr_ok;      // address accepts writes
    logic        ctrl_wr;
    logic [31:0] rd_data;
    logic        sticky_err; // illegal transition seen since last clear
    logic        dir_q;

    assign setup   = psel & ~penable;
    assign access  = psel & penable;
    assign ctrl_wr = access & pwrite & (enc_reg_t'(paddr) == reg_ctrl);

    // ------------------------------------------------------------------
    // address decode and read mux
    // ------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        wr_ok   = 1'b0;
        case (enc_reg_t'(paddr))
            reg_position: rd_data = position;
            reg_period:   rd_data = meas.period;
            reg_accel:    rd_data = meas.accel;
            reg_tcur:     rd_data = meas.t_cur;
            reg_status:   rd_data = {30'd0, dir_q, sticky_err};
            reg_ctrl:     wr_ok   = 1'b1;        // reads back as 0
            default:      addr_ok = 1'b0;        // hole in the map
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prdata         <= '0;
            pready         <= 1'b0;
            pslverr        <= 1'b0;
            clear_position <= 1'b0;
            sticky_err     <= 1'b0;
            dir_q          <= 1'b0;
        end else begin
            pready  <= setup;                    // always ready in the access cycle
            pslverr <= setup & (~addr_ok | (pwrite & ~wr_ok));
            prdata  <= (setup & ~pwrite) ? rd_data : '0;
            clear_position <= ctrl_wr & pwdata[0];
            // a new illegal edge beats a clear on the same cycle
            sticky_err <= (sticky_err & ~(ctrl_wr & pwdata[1]))
                        | (evt.valid & evt.illegal);
            if (evt.valid && !evt.illegal)
                dir_q <= evt.dir;
        end
    end

endmodule

`default_nettype wire

/* source/enc_top.sv */
// Top level of the quadrature encoder interface.
// Encoder pins feed the edge decoder, its events drive the period
// measurement, and both are read back through the APB register block.
`timescale 1ns/1ps
`default_nettype none

`include "enc_config.svh"

module enc_top #(
    parameter int CNT_WIDTH = `ENC_CNT_WIDTH  // interval counter width
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        a,          // encoder line a, asynchronous
    input  logic        b,          // encoder line b, asynchronous
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import enc_pkg::*;

    enc_event_t         evt;
    logic signed [31:0] position;
    enc_meas_t          meas;
    logic               clear_position;

    enc_edge_decode decode_i (
        .clk            (clk),
        .reset          (reset),
        .a              (a),
        .b              (b),
        .clear_position (clear_position),
        .evt            (evt),
        .position       (position)
    );

    enc_period_meas #(
        .CNT_WIDTH (CNT_WIDTH)
    ) meas_i (
        .clk   (clk),
        .reset (reset),
        .evt   (evt),
        .meas  (meas)
    );

    enc_apb_regs regs_i (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .evt            (evt),
        .position       (position),
        .meas           (meas),
        .clear_position (clear_position)
    );

endmodule

`default_nettype wire

/* testbench/enc_props.sv */
// Protocol and event checks for the encoder interface.
// Bound into the APB register block, which also sees the decoder
// outputs (event, position, clear pulse) on its ports.
`timescale 1ns/1ps
`default_nettype none

module enc_props (
    input logic                clk,
    input logic                reset,
    input logic                psel,
    input logic                penable,
    input logic                pready,
    input logic                pslverr,
    input enc_pkg::enc_event_t evt,
    input logic signed [31:0]  position,
    input logic                clear_position
);
    import enc_pkg::*;

    int unsigned violations = 0;    // summed up by the testbench

    // zero wait states, every access cycle is ready
    apb_ready: assert property (@(posedge clk) disable iff (!reset)
        psel && penable |-> pready)
    else begin
        violations++;
        $error("pready low in an APB access cycle");
    end

    apb_err_window: assert property (@(posedge clk) disable iff (!reset)
        pslverr |-> psel && penable)
    else begin
        violations++;
        $error("pslverr outside the APB access cycle");
    end

    // edges are spaced by the synchronizer, never back to back
    evt_single: assert property (@(posedge clk) disable iff (!reset)
        evt.valid |=> !evt.valid)
    else begin
        violations++;
        $error("evt.valid high on two cycles in a row");
    end

    // position moves with the event strobe or one cycle after a clear
    pos_stable: assert property (@(posedge clk) disable iff (!reset)
        $changed(position) |-> evt.valid || $past(clear_position))
    else begin
        violations++;
        $error("position changed without an event or a clear");
    end

endmodule

bind enc_apb_regs enc_props props_i (
    .clk            (clk),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pready         (pready),
    .pslverr        (pslverr),
    .evt            (evt),
    .position       (position),
    .clear_position (clear_position)
);

`default_nettype wire

/* testbench/enc_tb.sv */
// Testbench for the quadrature encoder interface.
// Reads motion tests from the golden file, steps the a and b lines,
// then reads the APB registers and compares them with the expected
// words. A few extra runs use random step intervals, then bad APB
// accesses are tried. Inputs change 1 ns after the rising clock edge.
`timescale 1ns/1ps
`default_nettype none

`include "enc_config.svh"

module enc_tb;

    localparam int MAX_TESTS  = 32;
    localparam int RAND_TESTS = 3;
    localparam int RAND_STEPS = 6;

    logic        clk = 1'b0;
    logic        reset;
    logic        a;
    logic        b;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [1:0]  quad_idx;              // place in the 00 10 11 01 cycle
    int          checks;
    int          value_errs;
    int          other_errs;
    longint      limit_ns;              // watchdog budget, 0 until known
    integer      seed;

    string       t_name   [MAX_TESTS];
    int          t_steps  [MAX_TESTS];
    int          t_ival   [MAX_TESTS];  // cycles between pin changes
    int          t_dir    [MAX_TESTS];
    int          t_pos    [MAX_TESTS];
    logic [31:0] t_period [MAX_TESTS];
    logic [31:0] t_accel  [MAX_TESTS];
    int          n_tests;

    enc_top #(
        .CNT_WIDTH (12)                 // overflow reachable in a short run
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;              // 100 ns period

    // ------------------------------------------------------------------
    // bus and pin tasks
    // ------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (pready !== 1'b1 && n < 4) begin
            next_cycle();
            n++;
        end
        if (pready !== 1'b1) begin
            other_errs++;
            $display("no pready within 4 cycles of the access phase, address %h", paddr);
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;                 // setup cycle
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;                 // access cycle
        wait_ready();
        data = prdata;
        err  = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        wait_ready();
        err = pslverr;
        next_cycle();                   // write lands on this edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // CTRL 3 zeroes position and the sticky flag, position one cycle later
    task automatic clear_all(input string test);
        logic err;
        apb_write(`ENC_ADDR_CTRL, 32'd3, err);
        if (err !== 1'b0) begin
            other_errs++;
            $display("%s: CTRL write answered with an error response", test);
        end
        next_cycle();
    endtask

    task automatic step_encoder(input int dir, input int interval);
        if (dir == 2)
            quad_idx = quad_idx + 2'd2; // both lines flip at once
        else if (dir == 1)
            quad_idx = quad_idx + 2'd1;
        else
            quad_idx = quad_idx - 2'd1;
        a = quad_idx[1] ^ quad_idx[0];  // gray order, a leads b going forward
        b = quad_idx[1];
        repeat (interval) next_cycle();
    endtask

    // ------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------
    task automatic compare_word(input string test, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errs++;
            $display("Fail %s %s expected %h actual %h", test, field, expected, actual);
        end
    endtask

    task automatic check_reg(input string test, input string field, input logic [7:0] addr,
                             input logic [31:0] expected, input logic [31:0] mask);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        if (err !== 1'b0) begin
            other_errs++;
            $display("%s: read of %s got an error response", test, field);
        end
        compare_word(test, field, expected & mask, data & mask);
    endtask

    // count seen by a TCUR read after the last step: the count restarts
    // 4 cycles after the pin change (3 to the event, 1 to the queue),
    // the read follows the 8-cycle settle and two 2-cycle reads
    function automatic logic [31:0] tcur_expected(input int ival);
        int since_edge;
        since_edge = ival + 8 + 2 * 2 - 4;
        return 32'(since_edge >> `ENC_DROP_BITS);
    endfunction

    task automatic run_test(input string name, input int steps, input int ival,
                            input int dir, input int pos, input logic [31:0] period,
                            input logic [31:0] accel);
        if (dir != 2)
            clear_all(name);
        for (int i = 0; i < steps; i++)
            step_encoder(dir, ival);
        repeat (8) next_cycle();        // event, queue and period settle in 5
        check_reg(name, "position", `ENC_ADDR_POSITION, 32'(pos), 32'hffff_ffff);
        if (dir == 2 || steps == 0)
            check_reg(name, "status error bit", `ENC_ADDR_STATUS,
                      (dir == 2) ? 32'd1 : 32'd0, 32'd1);
        else
            check_reg(name, "status", `ENC_ADDR_STATUS,    // bit 1 is the last direction
                      (dir == 1) ? 32'd2 : 32'd0, 32'd3);
        if (dir == 2) begin
            clear_all(name);
            check_reg(name, "position after clear", `ENC_ADDR_POSITION, 32'd0, 32'hffff_ffff);
            check_reg(name, "status after clear", `ENC_ADDR_STATUS, 32'd0, 32'd1);
        end else begin
            if (steps > 0)
                check_reg(name, "tcur", `ENC_ADDR_TCUR, tcur_expected(ival), 32'hffff_ffff);
            check_reg(name, "period", `ENC_ADDR_PERIOD, period, 32'hffff_ffff);
            check_reg(name, "accel", `ENC_ADDR_ACCEL, accel, 32'hffff_ffff);
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int               fd;
        int               rc;
        logic [8*128-1:0] line_buf;
        string            nm;
        int               st;
        int               iv;
        int               dr;
        int               ps;
        logic [31:0]      pw;
        logic [31:0]      aw;
        int               rnd_t;
        longint           cycles;
        logic [31:0]      rd_data;
        logic             rd_err;

        reset      = 1'b0;
        a          = 1'b0;
        b          = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'h00;
        pwdata     = 32'd0;
        quad_idx   = 2'd0;
        checks     = 0;
        value_errs = 0;
        other_errs = 0;
        limit_ns   = 0;
        n_tests    = 0;
        seed       = 32'hc2e5_8ea6;

        fd = $fopen("testbench/enc_golden.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open testbench/enc_golden.txt");
        end
        while (fd != 0 && !$feof(fd) && n_tests < MAX_TESTS) begin
            rc = $fgets(line_buf, fd);
            // comment and blank lines do not yield seven fields
            if (rc > 0 && $sscanf(line_buf, "%s %d %d %d %d %h %h",
                                  nm, st, iv, dr, ps, pw, aw) == 7) begin
                t_name[n_tests]   = nm;
                t_steps[n_tests]  = st;
                t_ival[n_tests]   = iv;
                t_dir[n_tests]    = dr;
                t_pos[n_tests]    = ps;
                t_period[n_tests] = pw;
                t_accel[n_tests]  = aw;
                n_tests++;
            end
        end
        if (fd != 0)
            $fclose(fd);

        cycles = 0;
        for (int i = 0; i < n_tests; i++)
            cycles = cycles + longint'(t_steps[i]) * longint'(t_ival[i]) + 64'd200;
        cycles   = cycles + longint'(RAND_TESTS * (RAND_STEPS * 532 + 200));
        limit_ns = cycles * 64'd100;

        repeat (3) @(posedge clk);      // reset low for 3 cycles
        #1;
        reset = 1'b1;

        for (int i = 0; i < n_tests; i++)
            run_test(t_name[i], t_steps[i], t_ival[i], t_dir[i], t_pos[i],
                     t_period[i], t_accel[i]);

        // random intervals 20..531, four of them stay below the 4095 limit
        for (int r = 0; r < RAND_TESTS; r++) begin
            rnd_t = 20 + ($random(seed) & 32'h1ff);
            run_test($sformatf("rand_%0d", r), RAND_STEPS, rnd_t, 1, RAND_STEPS,
                     32'h4000_0000 | 32'((4 * rnd_t) >> 4),
                     {16'(rnd_t >> 4), 16'(rnd_t >> 4)});
        end

        apb_read(8'h18, rd_data, rd_err);           // hole in the map
        compare_word("bad_addr", "pslverr", 32'd1, {31'd0, rd_err});
        apb_write(`ENC_ADDR_PERIOD, 32'd0, rd_err); // read-only register
        compare_word("ro_write", "pslverr", 32'd1, {31'd0, rd_err});

        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errs, other_errs, dut_i.regs_i.props_i.violations);
        if (value_errs == 0 && other_errs == 0 && dut_i.regs_i.props_i.violations == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // watchdog sized from the step counts and intervals
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run is stuck", limit_ns);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/enc_pkg.sv
source/enc_edge_decode.sv
source/enc_period_meas.sv
source/enc_apb_regs.sv
source/enc_top.sv
testbench/enc_props.sv
testbench/enc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the encoder testbench with Verilator, run it, check sim.log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module enc_tb -f project.f -o enc_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/enc_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && echo "simulation passed" && exit 0
echo "simulation failed, see sim.log"
exit 1

/* testbench/enc_golden.txt */
# name  steps  interval  dir (1 fwd, 0 rev, 2 both lines)  position  period  accel
# dir 2 rows keep the position of the row before and check status instead
after_reset   0    0  1   0  800000ff  00ff00ff
fwd_t64       6   64  1   6  40000010  00040004
fwd_t100      8  100  1   8  40000019  00060006
illegal_both  3   20  2   8  00000000  00000000
rev_t80       7   80  0  -7  00000014  00050005
rev_t37       6   37  0  -6  00000009  00020002
fwd_t1023     6 1023  1   6  400000ff  003f003f
ovf_t1024     6 1024  1   6  c00000ff  00400040
ovf_t1100     6 1100  0  -6  800000ff  00440044
fwd_t50       6   50  1   6  4000000c  00030003
